// ==== verilog/pod_row_pkg.sv ====
`default_nettype none

package pod_row_pkg;

  // datapath widths
  localparam int data_width_gp = 32;
  localparam int addr_width_gp = 4;
  localparam int bank_id_width_gp = 2;
  localparam int src_tag_width_gp = 4;

  typedef enum logic {
    op_load  = 1'b0,
    op_store = 1'b1
  } op_e;

  typedef enum logic {
    status_ok     = 1'b0,
    status_denied = 1'b1
  } status_e;

  // request from the tile side, 43 bits
  typedef struct packed {
    op_e                         op;
    logic [bank_id_width_gp-1:0] bank;
    logic [addr_width_gp-1:0]    addr;
    logic [data_width_gp-1:0]    data;
    logic [src_tag_width_gp-1:0] src_tag;
  } req_s;

  // response back to the tile side, 37 bits
  typedef struct packed {
    logic [data_width_gp-1:0]    data;
    logic [src_tag_width_gp-1:0] src_tag;
    status_e                     status;
  } resp_s;

  // serial config payload
  // reset holds the whole row idle, write_protect turns stores away
  typedef struct packed {
    logic reset;
    logic write_protect;
  } tag_payload_s;

  localparam int tag_payload_width_gp = $bits(tag_payload_s);

endpackage

`default_nettype wire

// ==== verilog/pod_tag_client.sv ====
`timescale 1ns/10ps
`default_nettype none

module pod_tag_client (
  input  logic                       clk_i
  , input  logic                     reset_i
  , input  logic                     tag_v_i
  , input  logic                     tag_data_i
  , output pod_row_pkg::tag_payload_s payload_o
);

  localparam int width_lp = pod_row_pkg::tag_payload_width_gp;
  localparam int cnt_width_lp = (width_lp > 1) ? $clog2(width_lp) : 1;

  logic [width_lp-1:0]       shift_r;
  logic [cnt_width_lp-1:0]   cnt_r;
  logic                      commit_r;
  logic                      last_bit;
  pod_row_pkg::tag_payload_s payload_r;

  assign last_bit = tag_v_i & (cnt_r == cnt_width_lp'(width_lp - 1));

  // lsb first, so new bits enter at the top
  always_ff @(posedge clk_i) begin
    if (tag_v_i) begin
      shift_r <= width_lp'({tag_data_i, shift_r} >> 1);
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_r     <= '0;
      commit_r  <= 1'b0;
      payload_r <= '{reset: 1'b1, write_protect: 1'b0};
    end else begin
      commit_r <= last_bit;
      if (tag_v_i) begin
        cnt_r <= last_bit ? '0 : cnt_r + 1'b1;
      end
      // full payload lands one cycle after its last bit
      if (commit_r) begin
        payload_r <= pod_row_pkg::tag_payload_s'(shift_r);
      end
    end
  end

  assign payload_o = payload_r;

endmodule

`default_nettype wire

// ==== verilog/pod_fifo_small.sv ====
`timescale 1ns/10ps
`default_nettype none

module pod_fifo_small #(
  parameter type data_t = logic [7:0]
) (
  input  logic    clk_i
  , input  logic  reset_i
  , input  logic  v_i
  , input  data_t data_i
  , output logic  ready_o
  , output logic  v_o
  , output data_t data_o
  , input  logic  yumi_i
);

  data_t      mem_r [2];
  logic       wptr_r;
  logic       rptr_r;
  logic [1:0] count_r;
  logic       enq;
  logic       deq;

  assign ready_o = (count_r != 2'd2);
  assign v_o     = (count_r != 2'd0);
  assign data_o  = mem_r[rptr_r];

  assign enq = v_i & ready_o;
  assign deq = yumi_i;

  always_ff @(posedge clk_i) begin
    if (enq) begin
      mem_r[wptr_r] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wptr_r  <= 1'b0;
      rptr_r  <= 1'b0;
      count_r <= 2'd0;
    end else begin
      if (enq) wptr_r <= ~wptr_r;
      if (deq) rptr_r <= ~rptr_r;
      // simultaneous push and pop leaves the count alone
      case ({enq, deq})
        2'b10:   count_r <= count_r + 2'd1;
        2'b01:   count_r <= count_r - 2'd1;
        default: count_r <= count_r;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== verilog/pod_request_router.sv ====
`timescale 1ns/10ps
`default_nettype none

module pod_request_router #(
  parameter int num_banks_p = 4
) (
  input  logic                                        clk_i
  , input  logic                                      reset_i
  , input  logic                                      v_i
  , input  pod_row_pkg::op_e                          op_i
  , input  logic [pod_row_pkg::bank_id_width_gp-1:0]  bank_i
  , input  logic [pod_row_pkg::addr_width_gp-1:0]     addr_i
  , input  logic [pod_row_pkg::data_width_gp-1:0]     data_i
  , input  logic [pod_row_pkg::src_tag_width_gp-1:0]  src_tag_i
  , output logic                                      ready_o
  , output logic [num_banks_p-1:0]                    bank_v_o
  , output pod_row_pkg::op_e                          op_o
  , output logic [pod_row_pkg::addr_width_gp-1:0]     addr_o
  , output logic [pod_row_pkg::data_width_gp-1:0]     data_o
  , output logic [pod_row_pkg::src_tag_width_gp-1:0]  src_tag_o
  , input  logic [num_banks_p-1:0]                    bank_ready_i
);

  logic [num_banks_p-1:0] bank_onehot;
  logic [num_banks_p-1:0] valid_r;
  logic                   en_r;
  logic                   drain;
  logic                   accept;

  // bank ids past the last bank alias onto bank 0
  always_comb begin
    for (int i = 0; i < num_banks_p; i++) begin
      bank_onehot[i] = (int'(bank_i) == i);
    end
    if (bank_onehot == '0) begin
      bank_onehot[0] = 1'b1;
    end
  end

  assign drain   = |(valid_r & bank_ready_i);
  assign ready_o = en_r & (~(|valid_r) | drain);
  assign accept  = v_i & ready_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_r <= '0;
      en_r    <= 1'b0;
    end else begin
      en_r <= 1'b1;
      if (accept) valid_r <= bank_onehot;
      else if (drain) valid_r <= '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_o      <= op_i;
      addr_o    <= addr_i;
      data_o    <= data_i;
      src_tag_o <= src_tag_i;
    end
  end

  assign bank_v_o = valid_r;

endmodule

`default_nettype wire

// ==== verilog/pod_vcache_bank.sv ====
`timescale 1ns/10ps
`default_nettype none

module pod_vcache_bank #(
  parameter int words_p = 16
) (
  input  logic                                        clk_i
  , input  logic                                      reset_i
  , input  logic                                      write_protect_i
  , input  logic                                      v_i
  , input  pod_row_pkg::op_e                          op_i
  , input  logic [pod_row_pkg::addr_width_gp-1:0]     addr_i
  , input  logic [pod_row_pkg::data_width_gp-1:0]     data_i
  , input  logic [pod_row_pkg::src_tag_width_gp-1:0]  src_tag_i
  , output logic                                      ready_o
  , output logic                                      resp_v_o
  , output logic [pod_row_pkg::data_width_gp-1:0]     resp_data_o
  , output logic [pod_row_pkg::src_tag_width_gp-1:0]  resp_src_tag_o
  , output pod_row_pkg::status_e                      resp_status_o
  , input  logic                                      resp_yumi_i
);

  localparam int idx_width_lp = (words_p > 1) ? $clog2(words_p) : 1;

  pod_row_pkg::req_s                      fifo_in;
  pod_row_pkg::req_s                      fifo_req;
  logic                                   fifo_v;
  logic                                   pop;
  logic                                   is_store;
  logic [idx_width_lp-1:0]                idx;
  logic [pod_row_pkg::data_width_gp-1:0]  mem_r [words_p];
  logic                                   resp_v_r;

  // bank id is already spent by the router
  always_comb begin
    fifo_in.op      = op_i;
    fifo_in.bank    = '0;
    fifo_in.addr    = addr_i;
    fifo_in.data    = data_i;
    fifo_in.src_tag = src_tag_i;
  end

  pod_fifo_small #(
    .data_t(pod_row_pkg::req_s)
  ) req_fifo (
    .clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.v_i(v_i)
    ,.data_i(fifo_in)
    ,.ready_o(ready_o)
    ,.v_o(fifo_v)
    ,.data_o(fifo_req)
    ,.yumi_i(pop)
  );

  // take the next request once the response slot frees up
  assign pop      = fifo_v & (~resp_v_r | resp_yumi_i);
  assign is_store = (fifo_req.op == pod_row_pkg::op_store);
  assign idx      = idx_width_lp'(fifo_req.addr % words_p);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      resp_v_r <= 1'b0;
    end else if (pop) begin
      resp_v_r <= 1'b1;
    end else if (resp_yumi_i) begin
      resp_v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop) begin
      resp_src_tag_o <= fifo_req.src_tag;
      if (is_store) begin
        resp_data_o   <= fifo_req.data;
        resp_status_o <= write_protect_i ? pod_row_pkg::status_denied
                                         : pod_row_pkg::status_ok;
        if (!write_protect_i) mem_r[idx] <= fifo_req.data;
      end else begin
        resp_data_o   <= mem_r[idx];
        resp_status_o <= pod_row_pkg::status_ok;
      end
    end
  end

  assign resp_v_o = resp_v_r;

endmodule

`default_nettype wire

// ==== verilog/pod_response_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module pod_response_arbiter #(
  parameter int num_banks_p = 4
) (
  input  logic                                                      clk_i
  , input  logic                                                    reset_i
  , input  logic [num_banks_p-1:0]                                  bank_v_i
  , input  logic [num_banks_p-1:0][pod_row_pkg::data_width_gp-1:0]    bank_data_i
  , input  logic [num_banks_p-1:0][pod_row_pkg::src_tag_width_gp-1:0] bank_src_tag_i
  , input  pod_row_pkg::status_e [num_banks_p-1:0]                  bank_status_i
  , output logic [num_banks_p-1:0]                                  bank_yumi_o
  , output logic                                                    v_o
  , output logic [pod_row_pkg::data_width_gp-1:0]                   data_o
  , output logic [pod_row_pkg::src_tag_width_gp-1:0]                src_tag_o
  , output pod_row_pkg::status_e                                    status_o
  , input  logic                                                    ready_i
);

  localparam int sel_width_lp = (num_banks_p > 1) ? $clog2(num_banks_p) : 1;

  logic [sel_width_lp-1:0] last_r;
  logic [sel_width_lp-1:0] grant_idx;
  logic                    grant_found;
  logic                    fifo_ready;
  logic                    push;
  pod_row_pkg::resp_s      fifo_in;
  pod_row_pkg::resp_s      fifo_out;

  // search starts one past the last winner
  always_comb begin
    int cand;
    grant_found = 1'b0;
    grant_idx   = last_r;
    for (int k = 1; k <= num_banks_p; k++) begin
      cand = (int'(last_r) + k) % num_banks_p;
      if (!grant_found && bank_v_i[cand]) begin
        grant_found = 1'b1;
        grant_idx   = sel_width_lp'(cand);
      end
    end
  end

  assign push = grant_found & fifo_ready;

  always_comb begin
    bank_yumi_o = '0;
    if (push) bank_yumi_o[grant_idx] = 1'b1;
    fifo_in.data    = bank_data_i[grant_idx];
    fifo_in.src_tag = bank_src_tag_i[grant_idx];
    fifo_in.status  = bank_status_i[grant_idx];
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      last_r <= sel_width_lp'(num_banks_p - 1);
    end else if (push) begin
      last_r <= grant_idx;
    end
  end

  pod_fifo_small #(
    .data_t(pod_row_pkg::resp_s)
  ) out_fifo (
    .clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.v_i(grant_found)
    ,.data_i(fifo_in)
    ,.ready_o(fifo_ready)
    ,.v_o(v_o)
    ,.data_o(fifo_out)
    ,.yumi_i(v_o & ready_i)
  );

  assign data_o    = fifo_out.data;
  assign src_tag_o = fifo_out.src_tag;
  assign status_o  = fifo_out.status;

endmodule

`default_nettype wire

// ==== verilog/pod_vcache_row.sv ====
`timescale 1ns/10ps
`default_nettype none

module pod_vcache_row #(
  parameter int num_banks_p = 4
  , parameter int bank_words_p = 16
) (
  input  logic                                        clk_i
  , input  logic                                      reset_i

  // serial config
  , input  logic                                      tag_v_i
  , input  logic                                      tag_data_i

  // requests from the tile array
  , input  logic                                      req_v_i
  , input  pod_row_pkg::op_e                          req_op_i
  , input  logic [pod_row_pkg::bank_id_width_gp-1:0]  req_bank_i
  , input  logic [pod_row_pkg::addr_width_gp-1:0]     req_addr_i
  , input  logic [pod_row_pkg::data_width_gp-1:0]     req_data_i
  , input  logic [pod_row_pkg::src_tag_width_gp-1:0]  req_src_tag_i
  , output logic                                      req_ready_o

  // responses back to the tile array
  , output logic                                      resp_v_o
  , output logic [pod_row_pkg::data_width_gp-1:0]     resp_data_o
  , output logic [pod_row_pkg::src_tag_width_gp-1:0]  resp_src_tag_o
  , output pod_row_pkg::status_e                      resp_status_o
  , input  logic                                      resp_ready_i
);

  pod_row_pkg::tag_payload_s tag_payload;
  logic                      row_reset;

  pod_tag_client tag_client (
    .clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.tag_v_i(tag_v_i)
    ,.tag_data_i(tag_data_i)
    ,.payload_o(tag_payload)
  );

  // pod reset from the payload, or the chip reset while the payload is reloading
  assign row_reset = reset_i | tag_payload.reset;

  logic [num_banks_p-1:0]                   rtr_bank_v;
  logic [num_banks_p-1:0]                   rtr_bank_ready;
  pod_row_pkg::op_e                         rtr_op;
  logic [pod_row_pkg::addr_width_gp-1:0]    rtr_addr;
  logic [pod_row_pkg::data_width_gp-1:0]    rtr_data;
  logic [pod_row_pkg::src_tag_width_gp-1:0] rtr_src_tag;

  pod_request_router #(
    .num_banks_p(num_banks_p)
  ) router (
    .clk_i(clk_i)
    ,.reset_i(row_reset)
    ,.v_i(req_v_i)
    ,.op_i(req_op_i)
    ,.bank_i(req_bank_i)
    ,.addr_i(req_addr_i)
    ,.data_i(req_data_i)
    ,.src_tag_i(req_src_tag_i)
    ,.ready_o(req_ready_o)
    ,.bank_v_o(rtr_bank_v)
    ,.op_o(rtr_op)
    ,.addr_o(rtr_addr)
    ,.data_o(rtr_data)
    ,.src_tag_o(rtr_src_tag)
    ,.bank_ready_i(rtr_bank_ready)
  );

  logic [num_banks_p-1:0]                                  bank_resp_v;
  logic [num_banks_p-1:0]                                  bank_resp_yumi;
  logic [num_banks_p-1:0][pod_row_pkg::data_width_gp-1:0]    bank_resp_data;
  logic [num_banks_p-1:0][pod_row_pkg::src_tag_width_gp-1:0] bank_resp_src_tag;
  pod_row_pkg::status_e [num_banks_p-1:0]                  bank_resp_status;

  for (genvar b = 0; b < num_banks_p; b++) begin : bank_gen
    pod_vcache_bank #(
      .words_p(bank_words_p)
    ) bank (
      .clk_i(clk_i)
      ,.reset_i(row_reset)
      ,.write_protect_i(tag_payload.write_protect)
      ,.v_i(rtr_bank_v[b])
      ,.op_i(rtr_op)
      ,.addr_i(rtr_addr)
      ,.data_i(rtr_data)
      ,.src_tag_i(rtr_src_tag)
      ,.ready_o(rtr_bank_ready[b])
      ,.resp_v_o(bank_resp_v[b])
      ,.resp_data_o(bank_resp_data[b])
      ,.resp_src_tag_o(bank_resp_src_tag[b])
      ,.resp_status_o(bank_resp_status[b])
      ,.resp_yumi_i(bank_resp_yumi[b])
    );
  end

  pod_response_arbiter #(
    .num_banks_p(num_banks_p)
  ) arbiter (
    .clk_i(clk_i)
    ,.reset_i(row_reset)
    ,.bank_v_i(bank_resp_v)
    ,.bank_data_i(bank_resp_data)
    ,.bank_src_tag_i(bank_resp_src_tag)
    ,.bank_status_i(bank_resp_status)
    ,.bank_yumi_o(bank_resp_yumi)
    ,.v_o(resp_v_o)
    ,.data_o(resp_data_o)
    ,.src_tag_o(resp_src_tag_o)
    ,.status_o(resp_status_o)
    ,.ready_i(resp_ready_i)
  );

endmodule

`default_nettype wire

// ==== testbench/pod_row_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module pod_row_checker #(
  parameter int num_banks_p = 4
  , localparam int num_tags_lp = 2 ** pod_row_pkg::src_tag_width_gp
) (
  input  logic                                        clk_i
  , input  logic                                      resp_v_i
  , input  logic                                      resp_ready_i
  , input  logic [pod_row_pkg::data_width_gp-1:0]     resp_data_i
  , input  logic [pod_row_pkg::src_tag_width_gp-1:0]  resp_src_tag_i
  , input  pod_row_pkg::status_e                      resp_status_i
  , output logic [num_tags_lp-1:0]                    pending_o
  , output int                                        pass_count_o
  , output int                                        error_count_o
);

  // expected entries, indexed by source tag
  logic [pod_row_pkg::data_width_gp-1:0] exp_data [num_tags_lp];
  pod_row_pkg::status_e                  exp_status [num_tags_lp];
  string                                 exp_test [num_tags_lp];
  int                                    exp_bank [num_tags_lp];
  int                                    exp_seq [num_tags_lp];

  // per-bank issue and return counters for the order check
  int                     issue_cnt [num_banks_p] = '{default: 0};
  int                     resp_cnt [num_banks_p] = '{default: 0};
  logic [num_tags_lp-1:0] pending_r = '0;
  int                     pass_r = 0;
  int                     error_r = 0;

  assign pending_o     = pending_r;
  assign pass_count_o  = pass_r;
  assign error_count_o = error_r;

  task automatic expect_resp(input string test,
      input logic [pod_row_pkg::src_tag_width_gp-1:0] tag, input int bank,
      input logic [pod_row_pkg::data_width_gp-1:0] data, input pod_row_pkg::status_e status);
    exp_test[tag]   = test;
    exp_data[tag]   = data;
    exp_status[tag] = status;
    exp_bank[tag]   = bank;
    exp_seq[tag]    = issue_cnt[bank];
    issue_cnt[bank]++;
    pending_r[tag]  = 1'b1;
  endtask

  task automatic check_resp(input logic [pod_row_pkg::src_tag_width_gp-1:0] tag,
      input logic [pod_row_pkg::data_width_gp-1:0] data, input pod_row_pkg::status_e status);
    int   b;
    logic good;
    if (!pending_r[tag]) begin
      $display("response with tag %0d arrived but no request with that tag is outstanding",
               tag);
      error_r++;
    end else begin
      b              = exp_bank[tag];
      good           = 1'b1;
      pending_r[tag] = 1'b0;
      if (data !== exp_data[tag]) begin
        $display("CHECK FAILED %s expected %h actual %h (data, tag %0d)",
                 exp_test[tag], exp_data[tag], data, tag);
        good = 1'b0;
      end
      if (status !== exp_status[tag]) begin
        $display("CHECK FAILED %s expected %0d actual %0d (status, tag %0d)",
                 exp_test[tag], exp_status[tag], status, tag);
        good = 1'b0;
      end
      if (exp_seq[tag] != resp_cnt[b]) begin
        $display("response with tag %0d left bank %0d out of issue order in %s",
                 tag, b, exp_test[tag]);
        good = 1'b0;
      end
      resp_cnt[b]++;
      if (good) pass_r++;
      else error_r++;
    end
  endtask

  // outputs are settled mid-cycle
  always @(negedge clk_i) begin
    if (resp_v_i === 1'b1 && resp_ready_i === 1'b1) begin
      check_resp(resp_src_tag_i, resp_data_i, resp_status_i);
    end
  end

endmodule

`default_nettype wire

// ==== testbench/tb_pod_vcache_row.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_pod_vcache_row;

  localparam int num_banks_lp = 4;
  localparam int bank_words_lp = 16;
  localparam int timeout_lp = 1000;
  localparam int bank_w_lp = pod_row_pkg::bank_id_width_gp;
  localparam int addr_w_lp = pod_row_pkg::addr_width_gp;
  localparam int data_w_lp = pod_row_pkg::data_width_gp;
  localparam int tag_w_lp = pod_row_pkg::src_tag_width_gp;

  logic                 clk_i;
  logic                 reset_i;
  logic                 tag_v_i;
  logic                 tag_data_i;
  logic                 req_v_i;
  pod_row_pkg::op_e     req_op_i;
  logic [bank_w_lp-1:0] req_bank_i;
  logic [addr_w_lp-1:0] req_addr_i;
  logic [data_w_lp-1:0] req_data_i;
  logic [tag_w_lp-1:0]  req_src_tag_i;
  logic                 req_ready_o;
  logic                 resp_v_o;
  logic [data_w_lp-1:0] resp_data_o;
  logic [tag_w_lp-1:0]  resp_src_tag_o;
  pod_row_pkg::status_e resp_status_o;
  logic                 resp_ready_i;

  logic [2**tag_w_lp-1:0] pending;
  int                     checker_passes;
  int                     checker_errors;
  int                     tb_errors;
  logic [15:0]            lfsr_r;
  logic                   cur_wp;
  logic                   bp_mode;
  logic [tag_w_lp-1:0]    next_tag;
  logic [data_w_lp-1:0]   model_mem [num_banks_lp][bank_words_lp];

  pod_vcache_row #(
    .num_banks_p(num_banks_lp)
    ,.bank_words_p(bank_words_lp)
  ) pod_vcache_row_inst (
    .clk_i(clk_i), .reset_i(reset_i), .tag_v_i(tag_v_i), .tag_data_i(tag_data_i)
    ,.req_v_i(req_v_i), .req_op_i(req_op_i), .req_bank_i(req_bank_i)
    ,.req_addr_i(req_addr_i), .req_data_i(req_data_i), .req_src_tag_i(req_src_tag_i)
    ,.req_ready_o(req_ready_o), .resp_v_o(resp_v_o), .resp_data_o(resp_data_o)
    ,.resp_src_tag_o(resp_src_tag_o), .resp_status_o(resp_status_o)
    ,.resp_ready_i(resp_ready_i)
  );

  pod_row_checker #(
    .num_banks_p(num_banks_lp)
  ) checker_inst (
    .clk_i(clk_i), .resp_v_i(resp_v_o), .resp_ready_i(resp_ready_i)
    ,.resp_data_i(resp_data_o), .resp_src_tag_i(resp_src_tag_o)
    ,.resp_status_i(resp_status_o), .pending_o(pending)
    ,.pass_count_o(checker_passes), .error_count_o(checker_errors)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // 16-bit galois lfsr, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v      = {v[30:0], lfsr_r[0]};
      lfsr_r = lfsr_step(lfsr_r);
    end
    return v;
  endfunction

  function automatic int total_errors();
    return tb_errors + checker_errors;
  endfunction

  task automatic next_cycle();
    @(posedge clk_i);
    #5;
    if (bp_mode) resp_ready_i = (rand_bits(2) == 32'd0);
  endtask

  // payload goes in lsb first
  task automatic load_tag(input logic rst, input logic wp);
    pod_row_pkg::tag_payload_s p;
    p.reset         = rst;
    p.write_protect = wp;
    for (int i = 0; i < pod_row_pkg::tag_payload_width_gp; i++) begin
      tag_v_i    = 1'b1;
      tag_data_i = p[i];
      next_cycle();
    end
    tag_v_i = 1'b0;
    next_cycle();
    next_cycle();
    cur_wp = wp;
  endtask

  task automatic wait_ready(input logic level, input string what);
    int n;
    n = 0;
    while (req_ready_o !== level && n < timeout_lp) begin
      next_cycle();
      n++;
    end
    if (req_ready_o !== level) begin
      $display("%s: req_ready_o never went to %0b", what, level);
      tb_errors++;
    end
  endtask

  task automatic check_idle(input int cycles, input string what);
    for (int i = 0; i < cycles; i++) begin
      next_cycle();
      if (req_ready_o !== 1'b0) begin
        $display("CHECK FAILED %s expected 0 actual %b (req_ready_o in reset)",
                 what, req_ready_o);
        tb_errors++;
      end
      if (resp_v_o !== 1'b0) begin
        $display("CHECK FAILED %s expected 0 actual %b (resp_v_o in reset)",
                 what, resp_v_o);
        tb_errors++;
      end
    end
  endtask

  task automatic drain(input string what);
    int n;
    n = 0;
    while (pending != '0 && n < timeout_lp) begin
      next_cycle();
      n++;
    end
    if (pending != '0) begin
      $display("%s: responses for tags %b never came back", what, pending);
      tb_errors++;
    end
  endtask

  // expected response from the model memory at handshake time
  task automatic model_request(input pod_row_pkg::op_e op, input logic [bank_w_lp-1:0] bank,
      input logic [addr_w_lp-1:0] addr, input logic [data_w_lp-1:0] data, input string what);
    int                   b;
    int                   a;
    logic [data_w_lp-1:0] exp_data;
    pod_row_pkg::status_e exp_status;
    // bank ids past the row alias to bank 0
    b = (int'(bank) < num_banks_lp) ? int'(bank) : 0;
    a = int'(addr) % bank_words_lp;
    exp_data   = data;
    exp_status = pod_row_pkg::status_ok;
    if (op == pod_row_pkg::op_load) begin
      exp_data = model_mem[b][a];
    end else if (cur_wp) begin
      exp_status = pod_row_pkg::status_denied;
    end else begin
      model_mem[b][a] = data;
    end
    checker_inst.expect_resp(what, next_tag, b, exp_data, exp_status);
  endtask

  task automatic send_req(input pod_row_pkg::op_e op, input logic [bank_w_lp-1:0] bank,
      input logic [addr_w_lp-1:0] addr, input logic [data_w_lp-1:0] data, input string what);
    int   n;
    logic hs;
    n  = 0;
    hs = 1'b0;
    while (pending[next_tag] && n < timeout_lp) begin
      next_cycle();
      n++;
    end
    if (pending[next_tag]) begin
      $display("%s: tag %0d stayed outstanding too long", what, next_tag);
      tb_errors++;
    end else begin
      req_v_i       = 1'b1;
      req_op_i      = op;
      req_bank_i    = bank;
      req_addr_i    = addr;
      req_data_i    = data;
      req_src_tag_i = next_tag;
      n = 0;
      while (!hs && n < timeout_lp) begin
        @(negedge clk_i);
        hs = (req_ready_o === 1'b1);
        next_cycle();
        n++;
      end
      req_v_i = 1'b0;
      if (hs) begin
        model_request(op, bank, addr, data, what);
        next_tag++;
      end else begin
        $display("%s: request with tag %0d was never accepted", what, next_tag);
        tb_errors++;
      end
    end
  endtask

  task automatic random_ops(input int count, input string what);
    pod_row_pkg::op_e     op;
    logic [bank_w_lp-1:0] bank;
    logic [addr_w_lp-1:0] addr;
    logic [data_w_lp-1:0] data;
    for (int i = 0; i < count; i++) begin
      op   = (rand_bits(1) == 32'd1) ? pod_row_pkg::op_store : pod_row_pkg::op_load;
      bank = bank_w_lp'(rand_bits(bank_w_lp));
      addr = addr_w_lp'(rand_bits(addr_w_lp));
      data = data_w_lp'(rand_bits(data_w_lp));
      send_req(op, bank, addr, data, what);
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    $display("test %s finished with %0d errors", name, total_errors() - errs_before);
  endtask

  initial begin
    int errs_before;
    lfsr_r        = 16'd20474;
    reset_i       = 1'b1;
    tag_v_i       = 1'b0;
    tag_data_i    = 1'b0;
    req_v_i       = 1'b0;
    req_op_i      = pod_row_pkg::op_load;
    req_bank_i    = '0;
    req_addr_i    = '0;
    req_data_i    = '0;
    req_src_tag_i = '0;
    resp_ready_i  = 1'b1;
    tb_errors     = 0;
    cur_wp        = 1'b0;
    bp_mode       = 1'b0;
    next_tag      = '0;
    repeat (2) @(posedge clk_i);
    #5;
    reset_i = 1'b0;

    errs_before = total_errors();
    check_idle(20, "reset_hold");
    load_tag(1'b0, 1'b0);
    wait_ready(1'b1, "reset_hold");
    finish_test("reset_hold", errs_before);

    // every word gets a known value before random traffic
    errs_before = total_errors();
    for (int b = 0; b < num_banks_lp; b++) begin
      for (int a = 0; a < bank_words_lp; a++) begin
        send_req(pod_row_pkg::op_store, bank_w_lp'(b), addr_w_lp'(a),
                 data_w_lp'(rand_bits(data_w_lp)), "round_trip");
      end
    end
    random_ops(200, "round_trip");
    drain("round_trip");
    finish_test("round_trip", errs_before);

    errs_before = total_errors();
    load_tag(1'b0, 1'b1);
    random_ops(40, "write_protect");
    drain("write_protect");
    load_tag(1'b0, 1'b0);
    random_ops(40, "write_protect");
    drain("write_protect");
    finish_test("write_protect", errs_before);

    errs_before = total_errors();
    bp_mode = 1'b1;
    random_ops(150, "back_pressure");
    drain("back_pressure");
    bp_mode      = 1'b0;
    resp_ready_i = 1'b1;
    finish_test("back_pressure", errs_before);

    errs_before = total_errors();
    load_tag(1'b1, 1'b0);
    wait_ready(1'b0, "pod_reset");
    check_idle(10, "pod_reset");
    load_tag(1'b0, 1'b0);
    wait_ready(1'b1, "pod_reset");
    // memory survives the pod reset
    for (int b = 0; b < num_banks_lp; b++) begin
      for (int a = 0; a < bank_words_lp; a++) begin
        send_req(pod_row_pkg::op_load, bank_w_lp'(b), addr_w_lp'(a), '0, "pod_reset");
      end
    end
    random_ops(20, "pod_reset");
    drain("pod_reset");
    finish_test("pod_reset", errs_before);

    $display("tests done: %0d responses matched, %0d errors", checker_passes, total_errors());
    if (total_errors() == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
verilog/pod_row_pkg.sv
verilog/pod_tag_client.sv
verilog/pod_fifo_small.sv
verilog/pod_request_router.sv
verilog/pod_vcache_bank.sv
verilog/pod_response_arbiter.sv
verilog/pod_vcache_row.sv
testbench/pod_row_checker.sv
testbench/tb_pod_vcache_row.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and look for the pass line
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f src.f \
  --top-module tb_pod_vcache_row -o sim_tb_pod_vcache_row
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/sim_tb_pod_vcache_row)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qF "PASS: all tests"; then
  exit 0
else
  exit 1
fi
